/* dds_defs.svh */
`ifndef DDS_DEFS_SVH
`define DDS_DEFS_SVH

// datapath widths
`define DDS_PHASE_W     32
`define DDS_SAMPLE_W    12
`define DDS_LFSR_W      5
`define DDS_TABLE_BITS  6    // 64 sine entries

// AXI4-Lite bus
`define AXI_ADDR_W      4
`define AXI_DATA_W      32

// register offsets
`define REG_CTRL        4'h0
`define REG_TUNING      4'h4
`define REG_BIT_PERIOD  4'h8
`define REG_STATUS      4'hC

// response codes
`define RESP_OKAY       2'd0
`define RESP_SLVERR     2'd2

// lfsr x^5 + x^3 + 1, maximal length 31
`define LFSR_SEED       5'b00001
`define LFSR_TAP_A      4
`define LFSR_TAP_B      2

`endif

/* dds_sine_table.svh */
// one full sine period, round(2047 * sin(2*pi*k/64))
// included inside a module body after importing dds_pkg
localparam sample_t sine_table [64] = '{
   12'sd0,     12'sd201,   12'sd399,   12'sd594,
   12'sd783,   12'sd965,   12'sd1137,  12'sd1299,
   12'sd1447,  12'sd1582,  12'sd1702,  12'sd1805,
   12'sd1891,  12'sd1959,  12'sd2008,  12'sd2037,
   12'sd2047,  12'sd2037,  12'sd2008,  12'sd1959,   // peak at k = 16
   12'sd1891,  12'sd1805,  12'sd1702,  12'sd1582,
   12'sd1447,  12'sd1299,  12'sd1137,  12'sd965,
   12'sd783,   12'sd594,   12'sd399,   12'sd201,
   12'sd0,    -12'sd201,  -12'sd399,  -12'sd594,    // negative half
  -12'sd783,  -12'sd965,  -12'sd1137, -12'sd1299,
  -12'sd1447, -12'sd1582, -12'sd1702, -12'sd1805,
  -12'sd1891, -12'sd1959, -12'sd2008, -12'sd2037,
  -12'sd2047, -12'sd2037, -12'sd2008, -12'sd1959,
  -12'sd1891, -12'sd1805, -12'sd1702, -12'sd1582,
  -12'sd1447, -12'sd1299, -12'sd1137, -12'sd965,
  -12'sd783,  -12'sd594,  -12'sd399,  -12'sd201
};

/* dds_pkg.sv */
`include "dds_defs.svh"

package dds_pkg;

   // plain vectors with a meaning
   typedef logic        [`DDS_PHASE_W-1:0]  phase_t;
   typedef logic signed [`DDS_SAMPLE_W-1:0] sample_t;     // two's complement
   typedef logic        [`DDS_LFSR_W-1:0]   lfsr_t;
   typedef logic        [31:0]              bit_period_t; // clocks per data bit
   typedef logic        [`AXI_ADDR_W-1:0]   axi_addr_t;
   typedef logic        [`AXI_DATA_W-1:0]   axi_data_t;
   typedef logic        [1:0]               axi_resp_t;

   // waveform select, codes 6 and 7 fall back to sine
   typedef enum logic [2:0] {
      WAVE_SIN    = 3'd0,
      WAVE_COS    = 3'd1,
      WAVE_SQUARE = 3'd2,
      WAVE_SAW    = 3'd3,
      WAVE_ASK    = 3'd4,
      WAVE_BPSK   = 3'd5
   } wave_sel_e;

   // register block FSMs
   typedef enum logic {
      WR_IDLE,
      WR_RESP
   } wr_state_e;

   typedef enum logic {
      RD_IDLE,
      RD_DATA
   } rd_state_e;

endpackage

/* dds_regs.sv */
`timescale 1ns/1ns
`include "dds_defs.svh"

module dds_regs (
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  dds_pkg::axi_addr_t      awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  dds_pkg::axi_data_t      wdata,
   input  logic [`AXI_DATA_W/8-1:0] wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output dds_pkg::axi_resp_t      bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  dds_pkg::axi_addr_t      araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output dds_pkg::axi_data_t      rdata,
   output dds_pkg::axi_resp_t      rresp,
   output logic                    rvalid,
   input  logic                    rready,
   input  dds_pkg::lfsr_t          lfsr_state,
   output logic                    enable,
   output dds_pkg::wave_sel_e      wave_sel,
   output dds_pkg::phase_t         tuning_word,
   output dds_pkg::bit_period_t    bit_period
);
   import dds_pkg::*;

   wr_state_e wr_state;
   rd_state_e rd_state;
   logic      wr_fire;
   logic      wr_ok;
   axi_data_t rd_word;
   logic      rd_ok;

   ////////////////////////////////////////////////////////////////////////////
   // write channel, full words only (strobes not used)
   assign awready = (wr_state == WR_IDLE);
   assign wready  = (wr_state == WR_IDLE);
   assign bvalid  = (wr_state == WR_RESP);
   assign wr_fire = awready && awvalid && wvalid;
   assign wr_ok   = (awaddr == `REG_CTRL) || (awaddr == `REG_TUNING) ||
                    (awaddr == `REG_BIT_PERIOD);

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wr_state    <= WR_IDLE;
         enable      <= 1'b0;
         wave_sel    <= WAVE_SIN;
         tuning_word <= '0;
         bit_period  <= '0;
      end
      else if (wr_state == WR_IDLE)
      begin
         if (wr_fire)
         begin
            wr_state <= WR_RESP;
            if (awaddr == `REG_CTRL)
            begin
               enable   <= wdata[0];
               wave_sel <= wave_sel_e'(wdata[6:4]);
            end
            if (awaddr == `REG_TUNING)
               tuning_word <= wdata;
            if (awaddr == `REG_BIT_PERIOD)
               bit_period <= wdata;
         end
      end
      else if (bready)
         wr_state <= WR_IDLE;   // response taken
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (wr_fire)
         bresp <= wr_ok ? `RESP_OKAY : `RESP_SLVERR;
   end

   ////////////////////////////////////////////////////////////////////////////
   // read channel
   assign arready = (rd_state == RD_IDLE);
   assign rvalid  = (rd_state == RD_DATA);

   always_comb
   begin
      rd_ok = 1'b1;
      case (araddr)
         `REG_CTRL:       rd_word = {25'd0, wave_sel, 3'd0, enable};
         `REG_TUNING:     rd_word = tuning_word;
         `REG_BIT_PERIOD: rd_word = bit_period;
         `REG_STATUS:     rd_word = {{(`AXI_DATA_W - `DDS_LFSR_W){1'b0}}, lfsr_state};
         default:
         begin
            rd_word = '0;   // unmapped
            rd_ok   = 1'b0;
         end
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         rd_state <= RD_IDLE;
      else if (rd_state == RD_IDLE)
      begin
         if (arvalid)
            rd_state <= RD_DATA;
      end
      else if (rready)
         rd_state <= RD_IDLE;
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (arready && arvalid)
      begin
         rdata <= rd_word;
         rresp <= rd_ok ? `RESP_OKAY : `RESP_SLVERR;
      end
   end

   // responses must wait for the master
   bresp_held: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      bvalid && !bready |=> bvalid && $stable(bresp));
   rdata_held: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* lfsr_bit_source.sv */
`timescale 1ns/1ns
`include "dds_defs.svh"

module lfsr_bit_source (
   input  logic                 CLK_25MHZ,
   input  logic                 reset_from_key,
   input  logic                 enable,
   input  dds_pkg::bit_period_t bit_period,
   output dds_pkg::lfsr_t       lfsr_state,
   output logic                 data_bit
);
   import dds_pkg::*;

   bit_period_t bit_cnt;
   bit_period_t last_cnt;
   lfsr_t       lfsr_q;
   logic        feedback;

   // a period of 0 counts like a period of 1
   assign last_cnt = (bit_period == '0) ? '0 : bit_period - 1'b1;
   assign feedback = lfsr_q[`LFSR_TAP_A] ^ lfsr_q[`LFSR_TAP_B];

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         bit_cnt <= '0;
         lfsr_q  <= `LFSR_SEED;
      end
      else if (enable)   // hold everything while disabled
      begin
         if (bit_cnt >= last_cnt)
         begin
            bit_cnt <= '0;
            lfsr_q  <= {lfsr_q[`DDS_LFSR_W-2:0], feedback};   // one step per bit
         end
         else
            bit_cnt <= bit_cnt + 1'b1;
      end
   end

   assign lfsr_state = lfsr_q;
   assign data_bit   = lfsr_q[0];   // 31-bit pseudo-random stream

endmodule

/* dds_core.sv */
`timescale 1ns/1ns
`include "dds_defs.svh"

module dds_core (
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  logic               enable,
   input  dds_pkg::wave_sel_e wave_sel,
   input  dds_pkg::phase_t    tuning_word,
   input  logic               data_bit,
   output dds_pkg::sample_t   wave_out
);
   import dds_pkg::*;

   `include "dds_sine_table.svh"

   phase_t                    phase;
   logic [`DDS_TABLE_BITS-1:0] sin_idx;
   logic [`DDS_TABLE_BITS-1:0] cos_idx;
   sample_t                   sin_val;
   sample_t                   cos_val;
   sample_t                   squ_val;
   sample_t                   saw_val;
   sample_t                   ask_val;
   sample_t                   bpsk_val;
   sample_t                   wave_next;

   ////////////////////////////////////////////////////////////////////////////
   // phase accumulator, f_out = tuning_word * f_clk / 2^32
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else if (enable)
         phase <= phase + tuning_word;
      else
         phase <= '0;   // restart from zero on next enable
   end

   ////////////////////////////////////////////////////////////////////////////
   // waveforms from the current phase
   assign sin_idx = phase[`DDS_PHASE_W-1 -: `DDS_TABLE_BITS];
   assign cos_idx = sin_idx + 6'd16;   // quarter turn, wraps mod 64
   assign sin_val = sine_table[sin_idx];
   assign cos_val = sine_table[cos_idx];

   assign squ_val = phase[`DDS_PHASE_W-1] ? 12'sh800 : 12'sh7ff;   // -2048 / +2047
   assign saw_val = {~phase[`DDS_PHASE_W-1], phase[`DDS_PHASE_W-2 -: `DDS_SAMPLE_W-1]};

   // data bit keys the carrier
   assign ask_val  = data_bit ? sin_val : '0;
   assign bpsk_val = data_bit ? sin_val : -sin_val;   // table never hits -2048

   always_comb
   begin
      case (wave_sel)
         WAVE_COS:    wave_next = cos_val;
         WAVE_SQUARE: wave_next = squ_val;
         WAVE_SAW:    wave_next = saw_val;
         WAVE_ASK:    wave_next = ask_val;
         WAVE_BPSK:   wave_next = bpsk_val;
         default:     wave_next = sin_val;   // sine plus the two spare codes
      endcase
   end

   // output register, one cycle behind phase
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         wave_out <= '0;
      else if (enable)
         wave_out <= wave_next;
      else
         wave_out <= '0;
   end

   // disabling silences the output on the next edge
   quiet_when_off: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !enable |=> wave_out == '0);

endmodule

/* dds_top.sv */
`timescale 1ns/1ns
`include "dds_defs.svh"

module dds_top (
   input  logic                    CLK_25MHZ,
   input  logic                    reset_from_key,
   input  dds_pkg::axi_addr_t      awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  dds_pkg::axi_data_t      wdata,
   input  logic [`AXI_DATA_W/8-1:0] wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output dds_pkg::axi_resp_t      bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  dds_pkg::axi_addr_t      araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output dds_pkg::axi_data_t      rdata,
   output dds_pkg::axi_resp_t      rresp,
   output logic                    rvalid,
   input  logic                    rready,
   output dds_pkg::sample_t        wave_out,
   output logic                    data_bit
);
   import dds_pkg::*;

   // configuration from the register block
   logic        enable;
   wave_sel_e   wave_sel;
   phase_t      tuning_word;
   bit_period_t bit_period;
   lfsr_t       lfsr_state;   // back to STATUS

   dds_regs dds_regs_i (.*);

   lfsr_bit_source lfsr_bit_source_i (.*);

   dds_core dds_core_i (.*);

endmodule

/* tb_dds_top.sv */
`timescale 1ns/1ns
`include "dds_defs.svh"

module tb_dds_top;
   import dds_pkg::*;

   `include "dds_sine_table.svh"

   // reset, then rough cycle budgets of tests 1 to 5
   localparam int TEST_CYCLES = 10 + 40 + 120 + 600 + 600 + 150;
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

   logic                     CLK_25MHZ;
   logic                     reset_from_key;
   axi_addr_t                awaddr, araddr;
   axi_data_t                wdata, rdata;
   logic [`AXI_DATA_W/8-1:0] wstrb;
   logic                     awvalid, wvalid, bready, arvalid, rready;
   logic                     awready, wready, bvalid, arready, rvalid;
   axi_resp_t                bresp, rresp;
   sample_t                  wave_out;
   logic                     data_bit;

   // reference model state
   phase_t      m_phase, m_tun;
   sample_t     m_wave;
   lfsr_t       m_lfsr;
   bit_period_t m_cnt, m_per;
   logic        m_en;
   logic [2:0]  m_sel;
   axi_data_t   m_rdata;
   axi_resp_t   m_bresp, m_rresp;
   logic        m_bpend, m_rpend;   // response owed on each channel
   int          cycles = 0;
   int          seed;
   int          test_periods [3] = '{0, 1, 7};

   dds_top dds_top_i (.*);

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz
   end

   ////////////////////////////////////////////////////////////////////////////
   // failure reporting and compare tasks
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_sample(input string name, input sample_t exp, input sample_t act);
      if (act !== exp)
         abort_run($sformatf("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         abort_run($sformatf("Fail at %0t ns: %s expected %b got %b", $time, name, exp, act));
   endtask

   task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
      if (act !== exp)
         abort_run($sformatf("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act));
   endtask

   task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
      if (act !== exp)
         abort_run($sformatf("Fail at %0t ns: %s expected %0d got %0d", $time, name, exp, act));
   endtask

   // expected sample for one phase and data bit
   function automatic sample_t ref_wave(input logic [2:0] sel, input phase_t ph,
                                        input logic bit_in);
      logic [5:0] idx;
      logic [5:0] cidx;
      sample_t    sn;
      idx  = ph[31:26];
      cidx = idx + 6'd16;   // quarter turn ahead
      sn   = sine_table[idx];
      case (sel)
         WAVE_COS:    ref_wave = sine_table[cidx];
         WAVE_SQUARE: ref_wave = ph[31] ? sample_t'(-2048) : sample_t'(2047);
         WAVE_SAW:    ref_wave = {~ph[31], ph[30:20]};
         WAVE_ASK:    ref_wave = bit_in ? sn : sample_t'(0);
         WAVE_BPSK:   ref_wave = bit_in ? sn : -sn;
         default:     ref_wave = sn;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // model update and compare, every edge
   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         m_phase = '0;
         m_wave  = '0;
         m_lfsr  = `LFSR_SEED;
         m_cnt   = '0;
         m_en    = 1'b0;
         m_sel   = 3'd0;
         m_tun   = '0;
         m_per   = '0;
         m_bpend = 1'b0;
         m_rpend = 1'b0;
      end
      else
      begin
         check_sample("wave_out", m_wave, wave_out);
         check_bit("data_bit", m_lfsr[0], data_bit);
         check_bit("awready", !m_bpend, awready);
         check_bit("wready", !m_bpend, wready);
         check_bit("bvalid", m_bpend, bvalid);
         check_bit("arready", !m_rpend, arready);
         check_bit("rvalid", m_rpend, rvalid);
         if (m_bpend && bready)
            check_resp("bresp", m_bresp, bresp);
         if (m_rpend && rready)
         begin
            check_data("rdata", m_rdata, rdata);
            check_resp("rresp", m_rresp, rresp);
         end
         if (m_rpend)
            m_rpend = !rready;
         else if (arvalid)   // read data taken from this edge's registers
         begin
            m_rpend = 1'b1;
            m_rresp = `RESP_OKAY;
            case (araddr)
               `REG_CTRL:       m_rdata = {25'd0, m_sel, 3'd0, m_en};
               `REG_TUNING:     m_rdata = m_tun;
               `REG_BIT_PERIOD: m_rdata = m_per;
               `REG_STATUS:     m_rdata = 32'(m_lfsr);
               default:
               begin
                  m_rdata = '0;
                  m_rresp = `RESP_SLVERR;
               end
            endcase
         end
         m_wave  = m_en ? ref_wave(m_sel, m_phase, m_lfsr[0]) : sample_t'(0);
         m_phase = m_en ? m_phase + m_tun : '0;
         if (m_en)
         begin
            if (m_cnt >= ((m_per == '0) ? '0 : m_per - 1))   // period 0 acts as 1
            begin
               m_cnt  = '0;
               m_lfsr = {m_lfsr[`DDS_LFSR_W-2:0], m_lfsr[`LFSR_TAP_A] ^ m_lfsr[`LFSR_TAP_B]};
            end
            else
               m_cnt = m_cnt + 1;
         end
         if (m_bpend)
            m_bpend = !bready;
         else if (awvalid && wvalid)   // write lands on acceptance edge
         begin
            m_bpend = 1'b1;
            m_bresp = `RESP_OKAY;
            case (awaddr)
               `REG_CTRL:
               begin
                  m_en  = wdata[0];
                  m_sel = wdata[6:4];
               end
               `REG_TUNING:     m_tun = wdata;
               `REG_BIT_PERIOD: m_per = wdata;
               default:         m_bresp = `RESP_SLVERR;
            endcase
         end
      end
   end

   always @(posedge CLK_25MHZ)
   begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT)
         abort_run("Timeout: the tests did not finish within the cycle limit");
   end

   ////////////////////////////////////////////////////////////////////////////
   // AXI4-Lite master tasks, random stalls on bready and rready
   task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
      logic done;
      @(posedge CLK_25MHZ);
      awaddr  <= addr;
      wdata   <= data;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      do
         @(posedge CLK_25MHZ);
      while (!awready);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      do
      begin
         bready <= ($urandom % 4) != 0;
         @(posedge CLK_25MHZ);
         done = bvalid && bready;
      end
      while (!done);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input axi_addr_t addr);
      logic done;
      @(posedge CLK_25MHZ);
      araddr  <= addr;
      arvalid <= 1'b1;
      do
         @(posedge CLK_25MHZ);
      while (!arready);
      arvalid <= 1'b0;
      do
      begin
         rready <= ($urandom % 4) != 0;
         @(posedge CLK_25MHZ);
         done = rvalid && rready;
      end
      while (!done);
      rready <= 1'b0;
   endtask

   initial
   begin
      seed = 19;
      void'($urandom(seed));
      reset_from_key = 1'b1;
      awaddr  = '0;
      araddr  = '0;
      wdata   = '0;
      wstrb   = '1;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (10) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;

      // reset values
      axi_read(`REG_STATUS);
      axi_read(`REG_CTRL);
      axi_read(`REG_TUNING);
      axi_read(`REG_BIT_PERIOD);

      // readback, then error responses
      axi_write(`REG_TUNING, $urandom);
      axi_write(`REG_BIT_PERIOD, $urandom);
      axi_write(`REG_CTRL, 32'h50);   // bpsk, still disabled
      axi_read(`REG_CTRL);
      axi_read(`REG_TUNING);
      axi_read(`REG_BIT_PERIOD);
      axi_write(`REG_STATUS, 32'h1f);
      axi_write(4'h2, $urandom);
      axi_read(4'h6);
      axi_read(`REG_STATUS);
      axi_read(`REG_CTRL);
      axi_read(`REG_TUNING);
      axi_read(`REG_BIT_PERIOD);

      // sine, cosine, square, saw under random tuning words
      axi_write(`REG_BIT_PERIOD, 32'd3);
      for (int w = 0; w < 4; w++)
      begin
         axi_write(`REG_CTRL, (w << 4) | 1);
         repeat (3)
         begin
            axi_write(`REG_TUNING, $urandom);
            repeat (40) @(posedge CLK_25MHZ);
         end
      end

      // bit periods 0, 1, 7 with ask then bpsk
      foreach (test_periods[i])
      begin
         axi_write(`REG_BIT_PERIOD, test_periods[i]);
         axi_write(`REG_CTRL, 32'h41);
         for (int k = 0; k < 8; k++)
         begin
            if (k == 4)
               axi_write(`REG_CTRL, 32'h51);
            repeat (4 * (test_periods[i] + 1)) @(posedge CLK_25MHZ);
            axi_read(`REG_STATUS);
         end
      end

      // disable freezes, enable restarts from phase zero
      axi_write(`REG_TUNING, 32'h0400_0000);
      axi_write(`REG_CTRL, 32'h01);
      repeat (20) @(posedge CLK_25MHZ);
      axi_write(`REG_CTRL, 32'h00);
      repeat (20) @(posedge CLK_25MHZ);
      axi_read(`REG_STATUS);
      axi_write(`REG_CTRL, 32'h01);
      repeat (20) @(posedge CLK_25MHZ);

      $display("Result: PASSED");
      $finish;
   end

endmodule

/* project.f */
+incdir+.
dds_pkg.sv
dds_regs.sv
lfsr_bit_source.sv
dds_core.sv
dds_top.sv
tb_dds_top.sv

/* Bender.yml */
package:
  name: dds_lfsr_source

export_include_dirs:
  - .

sources:
  - dds_pkg.sv
  - dds_regs.sv
  - lfsr_bit_source.sv
  - dds_core.sv
  - dds_top.sv
  - target: simulation
    files:
      - tb_dds_top.sv
